// ==== tb.f ====
hdl/div_cfg_pkg.sv
hdl/div_op_pkg.sv
hdl/div_lane.sv
hdl/div_dispatch.sv
hdl/div_collect.sv
hdl/vdiv_top.sv
test/vdiv_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= vdiv_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG) || (echo "simulation did not pass" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== test/vdiv_tb.sv ====
module vdiv_tb;

  import div_cfg_pkg::*;
  import div_op_pkg::*;

  localparam int W          = WORD_WIDTH;
  localparam int L          = DEF_NUM_LANES;
  localparam int BUS        = L * W;
  localparam int NUM_REQS   = 400;
  localparam int BP_LEN     = 1024;
  // worst-case iteration, gap and back-pressure per request
  localparam int MAX_CYCLES = NUM_REQS * 40;
  localparam logic [W-1:0] MOST_NEG = {1'b1, {(W-1){1'b0}}};

  logic           clk;
  logic           rst_n;
  logic           req_valid;
  logic           req_ready;
  div_req_t       req_ctrl;
  logic [BUS-1:0] req_dividend;
  logic [BUS-1:0] req_divisor;
  logic           rsp_valid;
  logic           rsp_ready;
  div_rsp_t       rsp_ctrl;
  logic [BUS-1:0] rsp_quotient;
  logic [BUS-1:0] rsp_remainder;

  // pre-generated stimulus
  logic [BUS-1:0] stim_dvd [0:NUM_REQS-1];
  logic [BUS-1:0] stim_dvs [0:NUM_REQS-1];
  div_sign_e      stim_op  [0:NUM_REQS-1];
  int             stim_gap [0:NUM_REQS-1];
  logic           bp_pattern [0:BP_LEN-1];

  // expected responses in request order
  logic [BUS-1:0]       exp_quo_q [$];
  logic [BUS-1:0]       exp_rem_q [$];
  logic [TAG_WIDTH-1:0] exp_tag_q [$];
  int                   rsp_count;
  int                   cycles;

  vdiv_top #(
    .DIV_WIDTH (W),
    .NUM_LANES (L)
  ) u_dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_valid     (req_valid),
    .req_ready     (req_ready),
    .req_ctrl      (req_ctrl),
    .req_dividend  (req_dividend),
    .req_divisor   (req_divisor),
    .rsp_valid     (rsp_valid),
    .rsp_ready     (rsp_ready),
    .rsp_ctrl      (rsp_ctrl),
    .rsp_quotient  (rsp_quotient),
    .rsp_remainder (rsp_remainder)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic stop_with_failure();
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped after a failed check");
  endtask

  task automatic check_value(input string name, input logic [BUS-1:0] got,
                             input logic [BUS-1:0] exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
      stop_with_failure();
    end
  endtask

  // truncating division where the remainder follows the dividend
  function automatic logic [W-1:0] quotient_of(input div_sign_e op, input logic [W-1:0] a,
                                               input logic [W-1:0] b);
    logic signed [W-1:0] sa;
    logic signed [W-1:0] sb;
    sa = a;
    sb = b;
    if (b == '0) return '1;
    if (op == DIV_SIGN && a == MOST_NEG && b == '1) return MOST_NEG;
    if (op == DIV_SIGN) return sa / sb;
    return a / b;
  endfunction

  function automatic logic [W-1:0] remainder_of(input div_sign_e op, input logic [W-1:0] a,
                                                input logic [W-1:0] b);
    logic signed [W-1:0] sa;
    logic signed [W-1:0] sb;
    sa = a;
    sb = b;
    if (b == '0) return a;
    if (op == DIV_SIGN && a == MOST_NEG && b == '1) return '0;
    if (op == DIV_SIGN) return sa % sb;
    return a % b;
  endfunction

  // biased operand pair for one lane
  task automatic gen_pair(output logic [W-1:0] a, output logic [W-1:0] b);
    int kind;
    kind = $urandom_range(0, 9);
    a = $urandom();
    b = $urandom();
    case (kind)
      0: b = '0;
      1: begin
        a = MOST_NEG;
        b = '1;
      end
      2: a = W'($urandom_range(0, 15));
      3: b = W'($urandom_range(1, 15));
      4: b = '1 - W'($urandom_range(0, 7));
      5: begin
        a = W'($urandom_range(0, 255));
        b = W'($urandom_range(1, 255));
      end
      default: ;
    endcase
  endtask

  task automatic send_request(input int n);
    logic [BUS-1:0] q;
    logic [BUS-1:0] r;
    req_valid       = 1'b1;
    req_ctrl.opcode = stim_op[n];
    req_ctrl.tag    = n[TAG_WIDTH-1:0];
    req_dividend    = stim_dvd[n];
    req_divisor     = stim_dvs[n];
    for (int l = 0; l < L; l++) begin
      q[l*W +: W] = quotient_of(stim_op[n], stim_dvd[n][l*W +: W], stim_dvs[n][l*W +: W]);
      r[l*W +: W] = remainder_of(stim_op[n], stim_dvd[n][l*W +: W], stim_dvs[n][l*W +: W]);
    end
    // req_ready is registered, so stable at the falling edge
    while (!req_ready) @(negedge clk);
    exp_quo_q.push_back(q);
    exp_rem_q.push_back(r);
    exp_tag_q.push_back(n[TAG_WIDTH-1:0]);
    @(negedge clk);
    req_valid = 1'b0;
  endtask

  task automatic take_response();
    logic [BUS-1:0]       q;
    logic [BUS-1:0]       r;
    logic [TAG_WIDTH-1:0] t;
    if (exp_tag_q.size() == 0) begin
      $display("response seen with no outstanding request");
      stop_with_failure();
    end
    q = exp_quo_q.pop_front();
    r = exp_rem_q.pop_front();
    t = exp_tag_q.pop_front();
    check_value("rsp_ctrl.tag", BUS'(rsp_ctrl.tag), BUS'(t));
    for (int l = 0; l < L; l++) begin
      check_value($sformatf("rsp_quotient[%0d]", l),
                  BUS'(rsp_quotient[l*W +: W]), BUS'(q[l*W +: W]));
      check_value($sformatf("rsp_remainder[%0d]", l),
                  BUS'(rsp_remainder[l*W +: W]), BUS'(r[l*W +: W]));
    end
    rsp_count++;
  endtask

  initial begin
    logic [W-1:0] a;
    logic [W-1:0] b;
    void'($urandom(32'hc5de_071a));
    rst_n        = 1'b0;
    req_valid    = 1'b0;
    req_ctrl     = '0;
    req_dividend = '0;
    req_divisor  = '0;
    rsp_ready    = 1'b0;
    rsp_count    = 0;
    for (int i = 0; i < BP_LEN; i++) begin
      bp_pattern[i] = ($urandom_range(0, 9) >= 3);
    end
    for (int n = 0; n < NUM_REQS; n++) begin
      stim_gap[n] = ($urandom_range(0, 3) == 0) ? int'($urandom_range(1, 6)) : 0;
      if (n > 0 && (n == 1 || $urandom_range(0, 4) == 0)) begin
        // exact repeat takes the reuse path in the lanes
        stim_op[n]  = stim_op[n-1];
        stim_dvd[n] = stim_dvd[n-1];
        stim_dvs[n] = stim_dvs[n-1];
      end else begin
        stim_op[n] = ($urandom_range(0, 1) == 1) ? DIV_SIGN : DIV_UNSIGN;
        for (int l = 0; l < L; l++) begin
          gen_pair(a, b);
          stim_dvd[n][l*W +: W] = a;
          stim_dvs[n][l*W +: W] = b;
        end
      end
      // first request right after reset has a zero dividend
      if (n == 0) begin
        stim_dvd[n] = '0;
        for (int l = 0; l < L; l++) begin
          stim_dvs[n][l*W +: W] = W'(l + 3);
        end
      end
      if (n < 2) begin
        stim_gap[n] = 0;
      end
    end
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    for (int n = 0; n < NUM_REQS; n++) begin
      repeat (stim_gap[n]) @(negedge clk);
      send_request(n);
    end
    wait (rsp_count == NUM_REQS);
    repeat (20) @(negedge clk);
    if (rsp_valid) begin
      $display("extra response at end of run");
      stop_with_failure();
    end else begin
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

  // random back-pressure and hold checks
  initial begin : response_monitor
    logic                 held;
    logic [BUS-1:0]       held_quo;
    logic [BUS-1:0]       held_rem;
    logic [TAG_WIDTH-1:0] held_tag;
    int                   bp_idx;
    held   = 1'b0;
    bp_idx = 0;
    forever begin
      @(negedge clk);
      if (held) begin
        check_value("rsp_valid", BUS'(rsp_valid), BUS'(1'b1));
        check_value("rsp_ctrl.tag (held)", BUS'(rsp_ctrl.tag), BUS'(held_tag));
        check_value("rsp_quotient (held)", rsp_quotient, held_quo);
        check_value("rsp_remainder (held)", rsp_remainder, held_rem);
      end
      rsp_ready = bp_pattern[bp_idx % BP_LEN];
      bp_idx++;
      held = 1'b0;
      if (rst_n && rsp_valid) begin
        if (rsp_ready) begin
          take_response();
        end else begin
          held     = 1'b1;
          held_quo = rsp_quotient;
          held_rem = rsp_remainder;
          held_tag = rsp_ctrl.tag;
        end
      end
    end
  end

  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: %0d of %0d responses after %0d cycles", rsp_count, NUM_REQS, cycles);
    stop_with_failure();
  end

endmodule

// ==== hdl/vdiv_top.sv ====
module vdiv_top #(
  parameter int DIV_WIDTH = div_cfg_pkg::WORD_WIDTH,
  parameter int NUM_LANES = div_cfg_pkg::DEF_NUM_LANES
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           req_valid,
  output logic                           req_ready,
  input  div_op_pkg::div_req_t           req_ctrl,
  input  logic [NUM_LANES*DIV_WIDTH-1:0] req_dividend,
  input  logic [NUM_LANES*DIV_WIDTH-1:0] req_divisor,
  output logic                           rsp_valid,
  input  logic                           rsp_ready,
  output div_op_pkg::div_rsp_t           rsp_ctrl,
  output logic [NUM_LANES*DIV_WIDTH-1:0] rsp_quotient,
  output logic [NUM_LANES*DIV_WIDTH-1:0] rsp_remainder
);

  import div_op_pkg::*;

  logic                           div_valid;
  div_sign_e                      lane_opcode;
  logic [NUM_LANES*DIV_WIDTH-1:0] lane_dividend;
  logic [NUM_LANES*DIV_WIDTH-1:0] lane_divisor;
  div_req_t                       busy_ctrl;
  logic                           take;
  logic [NUM_LANES-1:0]           lane_valid;
  logic [NUM_LANES*DIV_WIDTH-1:0] lane_quotient;
  logic [NUM_LANES*DIV_WIDTH-1:0] lane_remainder;

  div_dispatch #(
    .DIV_WIDTH (DIV_WIDTH),
    .NUM_LANES (NUM_LANES)
  ) u_dispatch (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_valid     (req_valid),
    .req_ready     (req_ready),
    .req_ctrl      (req_ctrl),
    .req_dividend  (req_dividend),
    .req_divisor   (req_divisor),
    .div_valid     (div_valid),
    .lane_opcode   (lane_opcode),
    .lane_dividend (lane_dividend),
    .lane_divisor  (lane_divisor),
    .busy_ctrl     (busy_ctrl),
    .take          (take)
  );

  // take doubles as every lane's result_ready
  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    div_lane #(
      .DIV_WIDTH (DIV_WIDTH)
    ) u_lane (
      .clk              (clk),
      .rst_n            (rst_n),
      .div_valid        (div_valid),
      .opcode           (lane_opcode),
      .dividend         (lane_dividend[i*DIV_WIDTH +: DIV_WIDTH]),
      .divisor          (lane_divisor[i*DIV_WIDTH +: DIV_WIDTH]),
      .result_quotient  (lane_quotient[i*DIV_WIDTH +: DIV_WIDTH]),
      .result_remainder (lane_remainder[i*DIV_WIDTH +: DIV_WIDTH]),
      .result_valid     (lane_valid[i]),
      .result_ready     (take)
    );
  end

  div_collect #(
    .DIV_WIDTH (DIV_WIDTH),
    .NUM_LANES (NUM_LANES)
  ) u_collect (
    .clk            (clk),
    .rst_n          (rst_n),
    .lane_valid     (lane_valid),
    .lane_quotient  (lane_quotient),
    .lane_remainder (lane_remainder),
    .busy_ctrl      (busy_ctrl),
    .take           (take),
    .rsp_valid      (rsp_valid),
    .rsp_ready      (rsp_ready),
    .rsp_ctrl       (rsp_ctrl),
    .rsp_quotient   (rsp_quotient),
    .rsp_remainder  (rsp_remainder)
  );

endmodule

// ==== hdl/div_collect.sv ====
module div_collect #(
  parameter int DIV_WIDTH = div_cfg_pkg::WORD_WIDTH,
  parameter int NUM_LANES = div_cfg_pkg::DEF_NUM_LANES
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [NUM_LANES-1:0]           lane_valid,
  input  logic [NUM_LANES*DIV_WIDTH-1:0] lane_quotient,
  input  logic [NUM_LANES*DIV_WIDTH-1:0] lane_remainder,
  input  div_op_pkg::div_req_t           busy_ctrl,
  output logic                           take,
  output logic                           rsp_valid,
  input  logic                           rsp_ready,
  output div_op_pkg::div_rsp_t           rsp_ctrl,
  output logic [NUM_LANES*DIV_WIDTH-1:0] rsp_quotient,
  output logic [NUM_LANES*DIV_WIDTH-1:0] rsp_remainder
);

  logic all_done;

  // lanes finish at different times
  assign all_done = &lane_valid;

  // only into an empty output register
  assign take = all_done && !rsp_valid;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_valid <= 1'b0;
    end else if (take) begin
      rsp_valid <= 1'b1;
    end else if (rsp_ready) begin
      rsp_valid <= 1'b0;
    end
  end

  // held while rsp_ready is low
  always_ff @(posedge clk) begin
    if (take) begin
      rsp_ctrl.tag  <= busy_ctrl.tag;
      rsp_quotient  <= lane_quotient;
      rsp_remainder <= lane_remainder;
    end
  end

endmodule

// ==== hdl/div_dispatch.sv ====
module div_dispatch #(
  parameter int DIV_WIDTH = div_cfg_pkg::WORD_WIDTH,
  parameter int NUM_LANES = div_cfg_pkg::DEF_NUM_LANES
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           req_valid,
  output logic                           req_ready,
  input  div_op_pkg::div_req_t           req_ctrl,
  input  logic [NUM_LANES*DIV_WIDTH-1:0] req_dividend,
  input  logic [NUM_LANES*DIV_WIDTH-1:0] req_divisor,
  output logic                           div_valid,
  output div_op_pkg::div_sign_e          lane_opcode,
  output logic [NUM_LANES*DIV_WIDTH-1:0] lane_dividend,
  output logic [NUM_LANES*DIV_WIDTH-1:0] lane_divisor,
  output div_op_pkg::div_req_t           busy_ctrl,
  input  logic                           take
);

  logic busy_q;
  logic accept;

  // one micro-op in the lanes at a time
  assign req_ready = !busy_q;
  assign accept    = req_valid && req_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
    end else if (accept) begin
      busy_q <= 1'b1;
    end else if (take) begin
      busy_q <= 1'b0;
    end
  end

  // operands held stable until take
  always_ff @(posedge clk) begin
    if (accept) begin
      busy_ctrl     <= req_ctrl;
      lane_dividend <= req_dividend;
      lane_divisor  <= req_divisor;
    end
  end

  assign div_valid   = busy_q;
  assign lane_opcode = busy_ctrl.opcode;

endmodule

// ==== hdl/div_lane.sv ====
module div_lane #(
  parameter int DIV_WIDTH = div_cfg_pkg::WORD_WIDTH
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   div_valid,
  input  div_op_pkg::div_sign_e  opcode,
  input  logic [DIV_WIDTH-1:0]   dividend,
  input  logic [DIV_WIDTH-1:0]   divisor,
  output logic [DIV_WIDTH-1:0]   result_quotient,
  output logic [DIV_WIDTH-1:0]   result_remainder,
  output logic                   result_valid,
  input  logic                   result_ready
);

  import div_cfg_pkg::*;
  import div_op_pkg::*;

  localparam int CNT_W = $clog2(DIV_WIDTH) + 1;

  typedef enum logic [1:0] {
    DIV_IDLE,
    DIV_WORKING,
    DIV_PRINT
  } state_e;

  state_e               state;
  state_e               next_state;

  // operand conditioning
  logic [DIV_WIDTH-1:0] dvd_abs;
  logic [DIV_WIDTH-1:0] dvs_abs;
  logic                 q_sgn_in;
  logic                 r_sgn_in;
  logic                 is_zero;
  logic                 is_ovf;
  logic                 is_same;
  logic [CNT_W-1:0]     clz;
  logic [CNT_W-1:0]     cnt_init;
  logic [CNT_W-1:0]     steps_left;

  // stored last operands for reuse
  logic [DIV_WIDTH-1:0] dvd_q;
  logic [DIV_WIDTH-1:0] dvs_q;
  logic                 q_sgn_q;
  logic                 r_sgn_q;

  logic [DIV_WIDTH-1:0] quo_q;
  logic [DIV_WIDTH-1:0] quo_d;
  logic [DIV_WIDTH-1:0] rem_q;
  logic [DIV_WIDTH-1:0] rem_d;
  logic [CNT_W-1:0]     cnt_q;
  logic [CNT_W-1:0]     cnt_d;

  // four unrolled steps per cycle
  logic [DIV_WIDTH-1:0] step_quo [0:4];
  logic [DIV_WIDTH-1:0] step_rem [0:4];

  function automatic logic [2:0] f_clz4(input logic [3:0] v);
    logic [2:0] n;
    casez (v)
      4'b1???: n = 3'd0;
      4'b01??: n = 3'd1;
      4'b001?: n = 3'd2;
      4'b0001: n = 3'd3;
      default: n = 3'd4;
    endcase
    return n;
  endfunction

  // msb of a half count flags an all-zero half
  function automatic logic [3:0] f_clz8(input logic [7:0] v);
    logic [2:0] hi;
    logic [2:0] lo;
    hi = f_clz4(v[7:4]);
    lo = f_clz4(v[3:0]);
    if (!hi[2]) return {1'b0, hi};
    if (!lo[2]) return {2'b01, lo[1:0]};
    return 4'b1000;
  endfunction

  function automatic logic [4:0] f_clz16(input logic [15:0] v);
    logic [3:0] hi;
    logic [3:0] lo;
    hi = f_clz8(v[15:8]);
    lo = f_clz8(v[7:0]);
    if (!hi[3]) return {1'b0, hi};
    if (!lo[3]) return {2'b01, lo[2:0]};
    return 5'b10000;
  endfunction

  function automatic logic [5:0] f_clz32(input logic [31:0] v);
    logic [4:0] hi;
    logic [4:0] lo;
    hi = f_clz16(v[31:16]);
    lo = f_clz16(v[15:0]);
    if (!hi[4]) return {1'b0, hi};
    if (!lo[4]) return {2'b01, lo[3:0]};
    return 6'b100000;
  endfunction

  // one restoring shift-and-subtract step
  function automatic void f_div_step(
    input  logic [DIV_WIDTH-1:0] rem_in,
    input  logic [DIV_WIDTH-1:0] quo_in,
    input  logic [DIV_WIDTH-1:0] dvs_in,
    output logic [DIV_WIDTH-1:0] rem_out,
    output logic [DIV_WIDTH-1:0] quo_out
  );
    logic [DIV_WIDTH:0] partial;
    logic [DIV_WIDTH:0] diff;
    partial = {rem_in, quo_in[DIV_WIDTH-1]};
    diff    = partial - {1'b0, dvs_in};
    if (partial >= {1'b0, dvs_in}) begin
      rem_out = diff[DIV_WIDTH-1:0];
      quo_out = {quo_in[DIV_WIDTH-2:0], 1'b1};
    end else begin
      rem_out = partial[DIV_WIDTH-1:0];
      quo_out = {quo_in[DIV_WIDTH-2:0], 1'b0};
    end
  endfunction

  always_comb begin
    dvd_abs  = dividend;
    dvs_abs  = divisor;
    q_sgn_in = 1'b0;
    r_sgn_in = 1'b0;
    if (opcode == DIV_SIGN) begin
      dvd_abs  = dividend[DIV_WIDTH-1] ? (~dividend + 1'b1) : dividend;
      dvs_abs  = divisor[DIV_WIDTH-1] ? (~divisor + 1'b1) : divisor;
      q_sgn_in = dividend[DIV_WIDTH-1] ^ divisor[DIV_WIDTH-1];
      r_sgn_in = dividend[DIV_WIDTH-1];
    end
  end

  assign is_zero = (divisor == '0);
  assign is_ovf  = (opcode == DIV_SIGN) && (divisor == '1) &&
                   (dividend == {1'b1, {(DIV_WIDTH-1){1'b0}}});
  assign is_same = (dvd_abs == dvd_q) && (dvs_abs == dvs_q) &&
                   (q_sgn_in == q_sgn_q) && (r_sgn_in == r_sgn_q);

  generate
    if (DIV_WIDTH == WORD_WIDTH) begin : g_clz32
      assign clz = f_clz32(dvd_abs);
    end else if (DIV_WIDTH == HWORD_WIDTH) begin : g_clz16
      assign clz = f_clz16(dvd_abs);
    end else begin : g_clz8
      assign clz = f_clz8(dvd_abs[BYTE_WIDTH-1:0]);
    end
  endgenerate

  // count of one means done
  assign cnt_init   = CNT_W'(DIV_WIDTH + 1) - clz;
  assign steps_left = cnt_q - 1'b1;

  always_comb begin
    step_quo[0] = quo_q;
    step_rem[0] = rem_q;
    for (int i = 0; i < 4; i++) begin
      f_div_step(step_rem[i], step_quo[i], dvs_q, step_rem[i+1], step_quo[i+1]);
    end
  end

  always_comb begin
    quo_d      = quo_q;
    rem_d      = rem_q;
    cnt_d      = cnt_q;
    next_state = state;
    case (state)
      DIV_IDLE: begin
        if (div_valid) begin
          if (is_zero) begin
            quo_d = '1;
            rem_d = dividend;
            cnt_d = CNT_W'(1);
          end else if (is_ovf) begin
            quo_d = {1'b1, {(DIV_WIDTH-1){1'b0}}};
            rem_d = '0;
            cnt_d = CNT_W'(1);
          end else if (is_same) begin
            // keep last result
            cnt_d = CNT_W'(1);
          end else begin
            quo_d = dvd_abs << clz;
            rem_d = '0;
            cnt_d = cnt_init;
          end
          next_state = (cnt_d == CNT_W'(1)) ? DIV_PRINT : DIV_WORKING;
        end
      end
      DIV_WORKING: begin
        if (div_valid) begin
          if (steps_left <= CNT_W'(4)) begin
            quo_d = step_quo[steps_left[2:0]];
            rem_d = step_rem[steps_left[2:0]];
            cnt_d = CNT_W'(1);
          end else begin
            quo_d = step_quo[4];
            rem_d = step_rem[4];
            cnt_d = cnt_q - CNT_W'(4);
          end
          next_state = (cnt_d == CNT_W'(1)) ? DIV_PRINT : DIV_WORKING;
        end
      end
      DIV_PRINT: begin
        if (div_valid && result_ready) begin
          next_state = DIV_IDLE;
        end
      end
      default: begin
        next_state = DIV_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= DIV_IDLE;
      cnt_q   <= '0;
      dvd_q   <= '0;
      dvs_q   <= '0;
      q_sgn_q <= 1'b0;
      r_sgn_q <= 1'b0;
    end else begin
      state <= next_state;
      cnt_q <= cnt_d;
      if (state == DIV_IDLE && div_valid) begin
        if (is_zero || is_ovf) begin
          // special results carry no sign fix-up
          dvd_q   <= '0;
          dvs_q   <= '0;
          q_sgn_q <= 1'b0;
          r_sgn_q <= 1'b0;
        end else if (!is_same) begin
          dvd_q   <= dvd_abs;
          dvs_q   <= dvs_abs;
          q_sgn_q <= q_sgn_in;
          r_sgn_q <= r_sgn_in;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    quo_q <= quo_d;
    rem_q <= rem_d;
  end

  assign result_valid     = (state == DIV_PRINT);
  assign result_quotient  = q_sgn_q ? (~quo_q + 1'b1) : quo_q;
  assign result_remainder = r_sgn_q ? (~rem_q + 1'b1) : rem_q;

endmodule

// ==== hdl/div_op_pkg.sv ====
package div_op_pkg;

  // signedness of the divide
  typedef enum logic {
    DIV_UNSIGN = 1'b0,
    DIV_SIGN   = 1'b1
  } div_sign_e;

  // request control that travels with the operands
  typedef struct packed {
    div_sign_e                        opcode;
    logic [div_cfg_pkg::TAG_WIDTH-1:0] tag;
  } div_req_t;

  // response control
  typedef struct packed {
    logic [div_cfg_pkg::TAG_WIDTH-1:0] tag;
  } div_rsp_t;

endpackage

// ==== hdl/div_cfg_pkg.sv ====
package div_cfg_pkg;

  // legal element widths
  localparam int WORD_WIDTH  = 32;
  localparam int HWORD_WIDTH = 16;
  localparam int BYTE_WIDTH  = 8;

  // default vector geometry
  localparam int DEF_NUM_LANES = 4;

  // micro-op tag
  localparam int TAG_WIDTH = 4;

endpackage
